// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam time HALF_PERIOD = 20ns;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // release away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// File: bench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;

    // operand source codes used in the table
    localparam int Z  = 0;
    localparam int IP = 1;
    localparam int IS = 2;
    localparam int RF = 100;
    localparam int FW = 200;

    localparam id_pkg::word_t IMM_P = 32'h0000_1234;
    localparam id_pkg::word_t IMM_S = 32'h0000_5678;

    // fields that ride through the slots unchanged
    localparam id_pkg::word_t              PC_P    = 32'h0000_0400;
    localparam id_pkg::word_t              PC_S    = 32'h0000_0404;
    localparam id_pkg::reg_addr_t          WADDR_P = 5'd20;
    localparam id_pkg::reg_addr_t          WADDR_S = 5'd21;
    localparam logic [id_pkg::ALUOP_W-1:0] ALUOP_P = 8'h11;
    localparam logic [id_pkg::ALUOP_W-1:0] ALUOP_S = 8'h22;

    typedef struct {
        int mode;
        int sel_p;
        int rsr_p, rs_p, rtr_p, rt_p;
        int rsr_s, rs_s, rtr_s, rt_s;
        int ex_allow, br, exc;
        int ld_ex, ld_mem, fwd;
        int e_allowin, e_exv, e_vs;
        int e_op1p, e_op2p, e_op1s, e_op2s;
        int e_dp, e_ds, e_selp, e_rs;
    } step_t;

    logic clk;
    logic arst_n_i;
    id_pkg::issue_mode_t issue_mode_i;
    id_pkg::word_t pc_p_i, pc_s_i, imm_p_i, imm_s_i;
    logic reg_write_p_i, reg_write_s_i;
    id_pkg::reg_addr_t waddr_p_i, waddr_s_i;
    id_pkg::alu_sel_t alusel_p_i, alusel_s_i;
    logic [id_pkg::ALUOP_W-1:0] aluop_p_i, aluop_s_i;
    logic rs_read_p_i, rs_read_s_i, rt_read_p_i, rt_read_s_i;
    id_pkg::reg_addr_t rs_p_i, rs_s_i, rt_p_i, rt_s_i;
    logic ex_allowin_i, branch_flag_i, exception_flag_i;
    logic ex_load_i, mem_load_i;
    id_pkg::reg_addr_t ex_load_waddr_i, mem_load_waddr_i;
    logic ex_w1_we_i, ex_w2_we_i, mem_w1_we_i, mem_w2_we_i, wb_w1_we_i, wb_w2_we_i;
    id_pkg::reg_addr_t ex_w1_addr_i, ex_w2_addr_i, mem_w1_addr_i, mem_w2_addr_i;
    id_pkg::reg_addr_t wb_w1_addr_i, wb_w2_addr_i;
    id_pkg::word_t ex_w1_data_i, ex_w2_data_i, mem_w1_data_i, mem_w2_data_i;
    id_pkg::word_t wb_w1_data_i, wb_w2_data_i;
    id_pkg::word_t rf_rs_p_i, rf_rt_p_i, rf_rs_s_i, rf_rt_s_i;
    logic id_allowin_o, id_ex_valid_o, valid_s_o, in_delay_p_o, in_delay_s_o;
    logic reg_write_p_o, reg_write_s_o;
    id_pkg::word_t pc_p_o, pc_s_o, opdata1_p_o, opdata2_p_o, opdata1_s_o, opdata2_s_o;
    id_pkg::reg_addr_t waddr_p_o, waddr_s_o, rs_p_o, rt_p_o, rs_s_o, rt_s_o;
    id_pkg::alu_sel_t alusel_p_o, alusel_s_o;
    logic [id_pkg::ALUOP_W-1:0] aluop_p_o, aluop_s_o;

    id_pkg::word_t rf_values [32];
    step_t         tbl [$];
    // register numbers latched by the slots at the last accepted issue
    int            held_rt_p;
    int            held_rs_s;
    int            held_rt_s;

    clk_gen u_clk (.clk_o(clk), .arst_n_o(arst_n_i));

    id_stage UUT (.*);

    // --------------------------------------------------
    // register file model
    // --------------------------------------------------
    assign rf_rs_p_i = rf_values[rs_p_o];
    assign rf_rt_p_i = rf_values[rt_p_o];
    assign rf_rs_s_i = rf_values[rs_s_o];
    assign rf_rt_s_i = rf_values[rt_s_o];

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic id_pkg::word_t port_value(input int k);
        return 32'hA5A5_0000 + id_pkg::word_t'(k);
    endfunction

    function automatic id_pkg::word_t resolve(input int code);
        if (code >= FW) begin
            return port_value(code - FW);
        end else if (code >= RF) begin
            return rf_values[code - RF];
        end else if (code == IP) begin
            return IMM_P;
        end else if (code == IS) begin
            return IMM_S;
        end
        return '0;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input string got, input string exp);
        fail_run($sformatf("Mismatch at %0t: %s got %s expected %s", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_word(input string name, input id_pkg::word_t got,
                              input id_pkg::word_t exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_reg(input string name, input id_pkg::reg_addr_t got,
                             input id_pkg::reg_addr_t exp);
        if (got !== exp) mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_sel(input string name, input id_pkg::alu_sel_t got,
                             input id_pkg::alu_sel_t exp);
        if (got !== exp) mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_aluop(input string name, input logic [id_pkg::ALUOP_W-1:0] got,
                               input logic [id_pkg::ALUOP_W-1:0] exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    // scenario 1 has several ports on r3, one on r4 and one on r0
    task automatic set_fwd(input int scen);
        ex_w2_we_i    = (scen == 1);
        ex_w2_addr_i  = 5'd0;
        ex_w2_data_i  = port_value(0);
        ex_w1_we_i    = (scen == 1);
        ex_w1_addr_i  = 5'd3;
        ex_w1_data_i  = port_value(1);
        mem_w2_we_i   = (scen == 1);
        mem_w2_addr_i = 5'd3;
        mem_w2_data_i = port_value(2);
        mem_w1_we_i   = 1'b0;
        mem_w1_addr_i = 5'd3;
        mem_w1_data_i = port_value(3);
        wb_w2_we_i    = (scen == 1);
        wb_w2_addr_i  = 5'd4;
        wb_w2_data_i  = port_value(4);
        wb_w1_we_i    = (scen == 1);
        wb_w1_addr_i  = 5'd3;
        wb_w1_data_i  = port_value(5);
    endtask

    task automatic drive_step(input step_t r);
        issue_mode_i     = id_pkg::issue_mode_t'(r.mode);
        alusel_p_i       = id_pkg::alu_sel_t'(r.sel_p);
        rs_read_p_i      = (r.rsr_p != 0);
        rs_p_i           = id_pkg::reg_addr_t'(r.rs_p);
        rt_read_p_i      = (r.rtr_p != 0);
        rt_p_i           = id_pkg::reg_addr_t'(r.rt_p);
        rs_read_s_i      = (r.rsr_s != 0);
        rs_s_i           = id_pkg::reg_addr_t'(r.rs_s);
        rt_read_s_i      = (r.rtr_s != 0);
        rt_s_i           = id_pkg::reg_addr_t'(r.rt_s);
        ex_allowin_i     = (r.ex_allow != 0);
        branch_flag_i    = (r.br != 0);
        exception_flag_i = (r.exc != 0);
        ex_load_i        = (r.ld_ex != 0);
        ex_load_waddr_i  = id_pkg::reg_addr_t'(r.ld_ex);
        mem_load_i       = (r.ld_mem != 0);
        mem_load_waddr_i = id_pkg::reg_addr_t'(r.ld_mem);
        set_fwd(r.fwd);
    endtask

    // every full primary in the table has a class other than ALU_NOP
    task automatic check_fields(input step_t r);
        logic full_p;
        logic full_s;
        full_p = (r.e_selp != 0);
        full_s = (r.e_vs != 0);
        check_word("pc_p_o", pc_p_o, full_p ? PC_P : '0);
        check_word("pc_s_o", pc_s_o, full_s ? PC_S : '0);
        check_bit("reg_write_p_o", reg_write_p_o, full_p);
        check_bit("reg_write_s_o", reg_write_s_o, full_s);
        check_reg("waddr_p_o", waddr_p_o, full_p ? WADDR_P : '0);
        check_reg("waddr_s_o", waddr_s_o, full_s ? WADDR_S : '0);
        check_aluop("aluop_p_o", aluop_p_o, full_p ? ALUOP_P : '0);
        check_aluop("aluop_s_o", aluop_s_o, full_s ? ALUOP_S : '0);
        check_sel("alusel_s_o", alusel_s_o, full_s ? id_pkg::ALU_ARITH : id_pkg::ALU_NOP);
        if (full_p) begin
            check_reg("rt_p_o", rt_p_o, id_pkg::reg_addr_t'(held_rt_p));
        end
        if (full_s) begin
            check_reg("rs_s_o", rs_s_o, id_pkg::reg_addr_t'(held_rs_s));
            check_reg("rt_s_o", rt_s_o, id_pkg::reg_addr_t'(held_rt_s));
        end
    endtask

    task automatic check_step(input step_t r);
        check_bit("id_allowin_o", id_allowin_o, r.e_allowin != 0);
        check_bit("id_ex_valid_o", id_ex_valid_o, r.e_exv != 0);
        check_bit("valid_s_o", valid_s_o, r.e_vs != 0);
        check_word("opdata1_p_o", opdata1_p_o, resolve(r.e_op1p));
        check_word("opdata2_p_o", opdata2_p_o, resolve(r.e_op2p));
        check_word("opdata1_s_o", opdata1_s_o, resolve(r.e_op1s));
        check_word("opdata2_s_o", opdata2_s_o, resolve(r.e_op2s));
        check_bit("in_delay_p_o", in_delay_p_o, r.e_dp != 0);
        check_bit("in_delay_s_o", in_delay_s_o, r.e_ds != 0);
        check_sel("alusel_p_o", alusel_p_o, id_pkg::alu_sel_t'(r.e_selp));
        if (r.e_rs >= 0) check_reg("rs_p_o", rs_p_o, id_pkg::reg_addr_t'(r.e_rs));
        check_fields(r);
    endtask

    task automatic build_table();
        // issue, operands from rf and imm
        tbl.push_back(step_t'{1, 1, 1, 1, 0, 2, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 0, 0, Z, Z, Z, Z, 0, 0, 0, -1});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 1, 0, RF+1, IP, Z, Z, 0, 0, 1, 1});
        tbl.push_back(step_t'{2, 2, 1, 3, 1, 4, 1, 0, 1, 6, 1, 0, 0, 0, 0, 0,
                              1, 0, 0, Z, Z, Z, Z, 0, 0, 0, -1});
        // back-pressure, then forwarding priority
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                              0, 1, 1, RF+3, RF+4, RF+0, RF+6, 0, 0, 2, 3});
        tbl.push_back(step_t'{1, 1, 1, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
                              0, 1, 1, FW+1, FW+4, RF+0, RF+6, 0, 0, 2, 3});
        // load-use in ex, in mem, and on the secondary
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 4, 0, 0,
                              0, 0, 1, RF+3, RF+4, RF+0, RF+6, 0, 0, 2, 3});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 3, 0,
                              0, 0, 1, RF+3, RF+4, RF+0, RF+6, 0, 0, 2, 3});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 6, 0, 0,
                              0, 0, 1, RF+3, RF+4, RF+0, RF+6, 0, 0, 2, 3});
        // lone branch, then its delay slot
        tbl.push_back(step_t'{1, 5, 1, 8, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 1, 1, RF+3, RF+4, RF+0, RF+6, 0, 0, 2, 3});
        tbl.push_back(step_t'{1, 1, 1, 9, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 1, 0, RF+8, IP, Z, Z, 0, 0, 5, 8});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 1, 0, RF+9, IP, Z, Z, 1, 0, 1, 9});
        // likely pair, then exception flush
        tbl.push_back(step_t'{2, 6, 1, 10, 0, 0, 1, 11, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 0, 0, Z, Z, Z, Z, 0, 0, 0, -1});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                              0, 1, 1, RF+10, IP, RF+11, IS, 0, 1, 6, 10});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0,
                              0, 1, 1, RF+10, IP, RF+11, IS, 0, 1, 6, 10});
        // branch flush without a pending delay slot
        tbl.push_back(step_t'{2, 6, 1, 10, 0, 0, 1, 11, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 0, 0, Z, Z, Z, Z, 0, 0, 0, -1});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0,
                              0, 0, 1, RF+10, IP, RF+11, IS, 0, 1, 6, 10});
        // branch flush with a pending delay slot
        tbl.push_back(step_t'{1, 5, 1, 8, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 0, 0, Z, Z, Z, Z, 0, 0, 0, -1});
        tbl.push_back(step_t'{2, 2, 1, 3, 1, 4, 1, 0, 1, 6, 1, 0, 0, 0, 0, 0,
                              1, 1, 0, RF+8, IP, Z, Z, 0, 0, 5, 8});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0,
                              0, 0, 1, RF+3, RF+4, RF+0, RF+6, 1, 0, 2, 3});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
                              0, 1, 0, RF+3, RF+4, Z, Z, 1, 0, 2, 3});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 1, 0, RF+3, RF+4, Z, Z, 1, 0, 2, 3});
        tbl.push_back(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                              1, 0, 0, Z, Z, Z, Z, 0, 0, 0, -1});
    endtask

    // --------------------------------------------------
    // run
    // --------------------------------------------------
    initial begin
        logic [15:0] lfsr;
        int          cnt;
        held_rt_p = 0;
        held_rs_s = 0;
        held_rt_s = 0;
        lfsr   = 16'd47;
        rf_values[0] = '0;
        for (int a = 1; a < 32; a++) begin
            for (int b = 0; b < 32; b++) begin
                rf_values[a] = {rf_values[a][30:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
        end
        pc_p_i        = PC_P;
        pc_s_i        = PC_S;
        imm_p_i       = IMM_P;
        imm_s_i       = IMM_S;
        reg_write_p_i = 1'b1;
        reg_write_s_i = 1'b1;
        waddr_p_i     = WADDR_P;
        waddr_s_i     = WADDR_S;
        aluop_p_i     = ALUOP_P;
        aluop_s_i     = ALUOP_S;
        alusel_s_i    = id_pkg::ALU_ARITH;
        drive_step(step_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0,
                           0, 0, 0, 0, 0, 0, 0, 0, 0, 0, -1});
        build_table();

        cnt = 0;
        while (arst_n_i !== 1'b1) begin
            @(posedge clk);
            cnt++;
            if (cnt > 50) fail_run("Reset was never released");
        end
        check_bit("id_allowin_o", id_allowin_o, 1'b1);
        check_bit("id_ex_valid_o", id_ex_valid_o, 1'b0);
        check_bit("valid_s_o", valid_s_o, 1'b0);

        foreach (tbl[i]) begin
            @(negedge clk);
            drive_step(tbl[i]);
            #10;
            check_step(tbl[i]);
            // an issue offered while allowin is high lands at the coming edge
            if (tbl[i].e_allowin != 0 && tbl[i].mode != 0) begin
                held_rt_p = tbl[i].rt_p;
                if (tbl[i].mode == 2) begin
                    held_rs_s = tbl[i].rs_s;
                    held_rt_s = tbl[i].rt_s;
                end
            end
        end

        // drain until the stage is empty
        cnt = 0;
        while (!(id_allowin_o && !id_ex_valid_o)) begin
            @(negedge clk);
            cnt++;
            if (cnt > 20) fail_run("Stage did not drain");
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: hdl/id_pkg.sv
package id_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]       word_t;

    // --------------------------------------------------
    // issue side and instruction class codes
    // --------------------------------------------------
    // instructions handed over by issue this cycle
    typedef enum logic [1:0] {
        NO_ISSUE     = 2'd0,
        SINGLE_ISSUE = 2'd1,
        DOUBLE_ISSUE = 2'd2
    } issue_mode_t;

    // branch and likely own a delay slot
    typedef enum logic [3:0] {
        ALU_NOP    = 4'd0,
        ALU_LOGIC  = 4'd1,
        ALU_ARITH  = 4'd2,
        ALU_LOAD   = 4'd3,
        ALU_STORE  = 4'd4,
        ALU_BRANCH = 4'd5,
        ALU_LIKELY = 4'd6
    } alu_sel_t;

endpackage

// File: hdl/id_slot_reg.sv
`timescale 1ns/1ps

module id_slot_reg (
    input  logic                       clk,
    input  logic                       load_i,
    input  id_pkg::word_t              pc_i,
    input  logic                       reg_write_i,
    input  id_pkg::reg_addr_t          waddr_i,
    input  id_pkg::alu_sel_t           alusel_i,
    input  logic [id_pkg::ALUOP_W-1:0] aluop_i,
    input  logic                       rs_read_i,
    input  id_pkg::reg_addr_t          rs_i,
    input  logic                       rt_read_i,
    input  id_pkg::reg_addr_t          rt_i,
    input  id_pkg::word_t              imm_i,
    output id_pkg::word_t              pc_o,
    output logic                       reg_write_o,
    output id_pkg::reg_addr_t          waddr_o,
    output id_pkg::alu_sel_t           alusel_o,
    output logic [id_pkg::ALUOP_W-1:0] aluop_o,
    output logic                       rs_read_o,
    output id_pkg::reg_addr_t          rs_o,
    output logic                       rt_read_o,
    output id_pkg::reg_addr_t          rt_o,
    output id_pkg::word_t              imm_o
);

    // contents only meaningful while the slot valid bit is set
    always_ff @(posedge clk) begin
        if (load_i) begin
            pc_o        <= pc_i;
            reg_write_o <= reg_write_i;
            waddr_o     <= waddr_i;
            alusel_o    <= alusel_i;
            aluop_o     <= aluop_i;
            rs_read_o   <= rs_read_i;
            rs_o        <= rs_i;
            rt_read_o   <= rt_read_i;
            rt_o        <= rt_i;
            imm_o       <= imm_i;
        end
    end

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                       clk,
    input  logic                       arst_n_i,
    // issue side
    input  id_pkg::issue_mode_t        issue_mode_i,
    input  id_pkg::word_t              pc_p_i,       pc_s_i,
    input  logic                       reg_write_p_i, reg_write_s_i,
    input  id_pkg::reg_addr_t          waddr_p_i,    waddr_s_i,
    input  id_pkg::alu_sel_t           alusel_p_i,   alusel_s_i,
    input  logic [id_pkg::ALUOP_W-1:0] aluop_p_i,    aluop_s_i,
    input  logic                       rs_read_p_i,  rs_read_s_i,
    input  id_pkg::reg_addr_t          rs_p_i,       rs_s_i,
    input  logic                       rt_read_p_i,  rt_read_s_i,
    input  id_pkg::reg_addr_t          rt_p_i,       rt_s_i,
    input  id_pkg::word_t              imm_p_i,      imm_s_i,
    output logic                       id_allowin_o,
    // execute side
    input  logic                       ex_allowin_i,
    input  logic                       branch_flag_i,
    input  logic                       exception_flag_i,
    output logic                       id_ex_valid_o,
    output logic                       valid_s_o,
    output id_pkg::word_t              pc_p_o,       pc_s_o,
    output logic                       reg_write_p_o, reg_write_s_o,
    output id_pkg::reg_addr_t          waddr_p_o,    waddr_s_o,
    output id_pkg::alu_sel_t           alusel_p_o,   alusel_s_o,
    output logic [id_pkg::ALUOP_W-1:0] aluop_p_o,    aluop_s_o,
    output id_pkg::word_t              opdata1_p_o,  opdata1_s_o,
    output id_pkg::word_t              opdata2_p_o,  opdata2_s_o,
    output logic                       in_delay_p_o, in_delay_s_o,
    // loads in flight
    input  logic                       ex_load_i,    mem_load_i,
    input  id_pkg::reg_addr_t          ex_load_waddr_i, mem_load_waddr_i,
    // forwarding ports
    input  logic                       ex_w1_we_i,   ex_w2_we_i,
    input  id_pkg::reg_addr_t          ex_w1_addr_i, ex_w2_addr_i,
    input  id_pkg::word_t              ex_w1_data_i, ex_w2_data_i,
    input  logic                       mem_w1_we_i,   mem_w2_we_i,
    input  id_pkg::reg_addr_t          mem_w1_addr_i, mem_w2_addr_i,
    input  id_pkg::word_t              mem_w1_data_i, mem_w2_data_i,
    input  logic                       wb_w1_we_i,   wb_w2_we_i,
    input  id_pkg::reg_addr_t          wb_w1_addr_i, wb_w2_addr_i,
    input  id_pkg::word_t              wb_w1_data_i, wb_w2_data_i,
    // register file
    output id_pkg::reg_addr_t          rs_p_o,       rt_p_o,
    output id_pkg::reg_addr_t          rs_s_o,       rt_s_o,
    input  id_pkg::word_t              rf_rs_p_i,    rf_rt_p_i,
    input  id_pkg::word_t              rf_rs_s_i,    rf_rt_s_i
);

    logic                       valid_p, valid_s, load_p, load_s, stall_p, stall_s;
    id_pkg::word_t              pc_p_q, pc_s_q, imm_p_q, imm_s_q;
    logic                       reg_write_p_q, reg_write_s_q;
    id_pkg::reg_addr_t          waddr_p_q, waddr_s_q;
    id_pkg::alu_sel_t           alusel_p_q, alusel_s_q;
    logic [id_pkg::ALUOP_W-1:0] aluop_p_q, aluop_s_q;
    logic                       rs_read_p_q, rs_read_s_q, rt_read_p_q, rt_read_s_q;
    id_pkg::word_t              op1_p, op2_p, op1_s, op2_s;

    id_stage_ctrl u_ctrl (
        .clk(clk), .arst_n_i(arst_n_i), .issue_mode_i(issue_mode_i),
        .ex_allowin_i(ex_allowin_i), .branch_flag_i(branch_flag_i),
        .exception_flag_i(exception_flag_i), .stall_p_i(stall_p), .stall_s_i(stall_s),
        .alusel_p_i(alusel_p_q), .id_allowin_o(id_allowin_o),
        .id_ex_valid_o(id_ex_valid_o), .valid_p_o(valid_p), .valid_s_o(valid_s),
        .load_p_o(load_p), .load_s_o(load_s),
        .in_delay_p_o(in_delay_p_o), .in_delay_s_o(in_delay_s_o)
    );

    // --------------------------------------------------
    // slot storage
    // --------------------------------------------------
    id_slot_reg u_slot_p (
        .clk(clk), .load_i(load_p),
        .pc_i(pc_p_i), .reg_write_i(reg_write_p_i), .waddr_i(waddr_p_i),
        .alusel_i(alusel_p_i), .aluop_i(aluop_p_i), .rs_read_i(rs_read_p_i),
        .rs_i(rs_p_i), .rt_read_i(rt_read_p_i), .rt_i(rt_p_i), .imm_i(imm_p_i),
        .pc_o(pc_p_q), .reg_write_o(reg_write_p_q), .waddr_o(waddr_p_q),
        .alusel_o(alusel_p_q), .aluop_o(aluop_p_q), .rs_read_o(rs_read_p_q),
        .rs_o(rs_p_o), .rt_read_o(rt_read_p_q), .rt_o(rt_p_o), .imm_o(imm_p_q)
    );

    id_slot_reg u_slot_s (
        .clk(clk), .load_i(load_s),
        .pc_i(pc_s_i), .reg_write_i(reg_write_s_i), .waddr_i(waddr_s_i),
        .alusel_i(alusel_s_i), .aluop_i(aluop_s_i), .rs_read_i(rs_read_s_i),
        .rs_i(rs_s_i), .rt_read_i(rt_read_s_i), .rt_i(rt_s_i), .imm_i(imm_s_i),
        .pc_o(pc_s_q), .reg_write_o(reg_write_s_q), .waddr_o(waddr_s_q),
        .alusel_o(alusel_s_q), .aluop_o(aluop_s_q), .rs_read_o(rs_read_s_q),
        .rs_o(rs_s_o), .rt_read_o(rt_read_s_q), .rt_o(rt_s_o), .imm_o(imm_s_q)
    );

    // --------------------------------------------------
    // operands and load-use hazards
    // --------------------------------------------------
    operand_fwd u_fwd_p (
        .rs_read_i(rs_read_p_q), .rt_read_i(rt_read_p_q), .rs_i(rs_p_o), .rt_i(rt_p_o),
        .imm_i(imm_p_q), .rf_rs_i(rf_rs_p_i), .rf_rt_i(rf_rt_p_i),
        .ex_w1_we_i(ex_w1_we_i), .ex_w1_addr_i(ex_w1_addr_i), .ex_w1_data_i(ex_w1_data_i),
        .ex_w2_we_i(ex_w2_we_i), .ex_w2_addr_i(ex_w2_addr_i), .ex_w2_data_i(ex_w2_data_i),
        .mem_w1_we_i(mem_w1_we_i), .mem_w1_addr_i(mem_w1_addr_i),
        .mem_w1_data_i(mem_w1_data_i), .mem_w2_we_i(mem_w2_we_i),
        .mem_w2_addr_i(mem_w2_addr_i), .mem_w2_data_i(mem_w2_data_i),
        .wb_w1_we_i(wb_w1_we_i), .wb_w1_addr_i(wb_w1_addr_i), .wb_w1_data_i(wb_w1_data_i),
        .wb_w2_we_i(wb_w2_we_i), .wb_w2_addr_i(wb_w2_addr_i), .wb_w2_data_i(wb_w2_data_i),
        .opdata1_o(op1_p), .opdata2_o(op2_p)
    );

    operand_fwd u_fwd_s (
        .rs_read_i(rs_read_s_q), .rt_read_i(rt_read_s_q), .rs_i(rs_s_o), .rt_i(rt_s_o),
        .imm_i(imm_s_q), .rf_rs_i(rf_rs_s_i), .rf_rt_i(rf_rt_s_i),
        .ex_w1_we_i(ex_w1_we_i), .ex_w1_addr_i(ex_w1_addr_i), .ex_w1_data_i(ex_w1_data_i),
        .ex_w2_we_i(ex_w2_we_i), .ex_w2_addr_i(ex_w2_addr_i), .ex_w2_data_i(ex_w2_data_i),
        .mem_w1_we_i(mem_w1_we_i), .mem_w1_addr_i(mem_w1_addr_i),
        .mem_w1_data_i(mem_w1_data_i), .mem_w2_we_i(mem_w2_we_i),
        .mem_w2_addr_i(mem_w2_addr_i), .mem_w2_data_i(mem_w2_data_i),
        .wb_w1_we_i(wb_w1_we_i), .wb_w1_addr_i(wb_w1_addr_i), .wb_w1_data_i(wb_w1_data_i),
        .wb_w2_we_i(wb_w2_we_i), .wb_w2_addr_i(wb_w2_addr_i), .wb_w2_data_i(wb_w2_data_i),
        .opdata1_o(op1_s), .opdata2_o(op2_s)
    );

    load_use_detect u_lu_p (
        .rs_read_i(rs_read_p_q), .rt_read_i(rt_read_p_q), .rs_i(rs_p_o), .rt_i(rt_p_o),
        .ex_load_i(ex_load_i), .ex_load_waddr_i(ex_load_waddr_i),
        .mem_load_i(mem_load_i), .mem_load_waddr_i(mem_load_waddr_i), .stall_o(stall_p)
    );

    load_use_detect u_lu_s (
        .rs_read_i(rs_read_s_q), .rt_read_i(rt_read_s_q), .rs_i(rs_s_o), .rt_i(rt_s_o),
        .ex_load_i(ex_load_i), .ex_load_waddr_i(ex_load_waddr_i),
        .mem_load_i(mem_load_i), .mem_load_waddr_i(mem_load_waddr_i), .stall_o(stall_s)
    );

    // empty slots read as zero
    assign valid_s_o     = valid_s;
    assign pc_p_o        = valid_p ? pc_p_q : '0;
    assign reg_write_p_o = valid_p && reg_write_p_q;
    assign waddr_p_o     = valid_p ? waddr_p_q : '0;
    assign alusel_p_o    = valid_p ? alusel_p_q : id_pkg::ALU_NOP;
    assign aluop_p_o     = valid_p ? aluop_p_q : '0;
    assign opdata1_p_o   = valid_p ? op1_p : '0;
    assign opdata2_p_o   = valid_p ? op2_p : '0;
    assign pc_s_o        = valid_s ? pc_s_q : '0;
    assign reg_write_s_o = valid_s && reg_write_s_q;
    assign waddr_s_o     = valid_s ? waddr_s_q : '0;
    assign alusel_s_o    = valid_s ? alusel_s_q : id_pkg::ALU_NOP;
    assign aluop_s_o     = valid_s ? aluop_s_q : '0;
    assign opdata1_s_o   = valid_s ? op1_s : '0;
    assign opdata2_s_o   = valid_s ? op2_s : '0;

endmodule

// File: hdl/id_stage_ctrl.sv
`timescale 1ns/1ps

module id_stage_ctrl (
    input  logic                clk,
    input  logic                arst_n_i,
    input  id_pkg::issue_mode_t issue_mode_i,
    input  logic                ex_allowin_i,
    input  logic                branch_flag_i,
    input  logic                exception_flag_i,
    input  logic                stall_p_i,
    input  logic                stall_s_i,
    input  id_pkg::alu_sel_t    alusel_p_i,
    output logic                id_allowin_o,
    output logic                id_ex_valid_o,
    output logic                valid_p_o,
    output logic                valid_s_o,
    output logic                load_p_o,
    output logic                load_s_o,
    output logic                in_delay_p_o,
    output logic                in_delay_s_o
);

    logic valid_p_q;
    logic valid_s_q;
    logic delay_slot_q;
    logic ready_go;
    logic flush_all;
    logic flush_s;
    logic is_branch_p;

    assign is_branch_p = (alusel_p_i == id_pkg::ALU_BRANCH) ||
                         (alusel_p_i == id_pkg::ALU_LIKELY);

    // pending delay slot keeps the primary alive
    assign flush_all = exception_flag_i || (branch_flag_i && !delay_slot_q);
    assign flush_s   = branch_flag_i && delay_slot_q;

    assign ready_go      = !stall_p_i && (!valid_s_q || !stall_s_i) && !branch_flag_i;
    assign id_allowin_o  = !valid_p_q || (ready_go && ex_allowin_i);
    assign id_ex_valid_o = valid_p_q && ready_go;

    // capture strobes for the slot registers
    assign load_p_o = id_allowin_o && (issue_mode_i != id_pkg::NO_ISSUE);
    assign load_s_o = id_allowin_o && (issue_mode_i == id_pkg::DOUBLE_ISSUE);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_p_q <= 1'b0;
            valid_s_q <= 1'b0;
        end else if (flush_all) begin
            valid_p_q <= 1'b0;
            valid_s_q <= 1'b0;
        end else begin
            if (id_allowin_o) begin
                valid_p_q <= (issue_mode_i != id_pkg::NO_ISSUE);
            end
            if (flush_s) begin
                valid_s_q <= 1'b0;
            end else if (id_allowin_o) begin
                valid_s_q <= (issue_mode_i == id_pkg::DOUBLE_ISSUE);
            end
        end
    end

    // --------------------------------------------------
    // delay slot tracking
    // --------------------------------------------------
    // lone branch leaves its delay slot for the next issue
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            delay_slot_q <= 1'b0;
        end else if (exception_flag_i) begin
            delay_slot_q <= 1'b0;
        end else if (id_ex_valid_o && ex_allowin_i) begin
            delay_slot_q <= !valid_s_q && is_branch_p;
        end
    end

    assign valid_p_o    = valid_p_q;
    assign valid_s_o    = valid_s_q;
    assign in_delay_p_o = valid_p_q && delay_slot_q;
    assign in_delay_s_o = valid_s_q && is_branch_p;

endmodule

// File: hdl/load_use_detect.sv
`timescale 1ns/1ps

module load_use_detect (
    input  logic              rs_read_i,
    input  logic              rt_read_i,
    input  id_pkg::reg_addr_t rs_i,
    input  id_pkg::reg_addr_t rt_i,
    input  logic              ex_load_i,
    input  id_pkg::reg_addr_t ex_load_waddr_i,
    input  logic              mem_load_i,
    input  id_pkg::reg_addr_t mem_load_waddr_i,
    output logic              stall_o
);

    // load result not yet on any forwarding port
    function automatic logic load_hit(
        input logic              ld,
        input id_pkg::reg_addr_t waddr
    );
        logic src_match;
        src_match = (rs_read_i && (waddr == rs_i)) || (rt_read_i && (waddr == rt_i));
        return ld && (waddr != '0) && src_match;
    endfunction

    always_comb begin
        stall_o = load_hit(ex_load_i, ex_load_waddr_i) ||
                  load_hit(mem_load_i, mem_load_waddr_i);
    end

endmodule

// File: hdl/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
    input  logic              rs_read_i,
    input  logic              rt_read_i,
    input  id_pkg::reg_addr_t rs_i,
    input  id_pkg::reg_addr_t rt_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::word_t     rf_rs_i,
    input  id_pkg::word_t     rf_rt_i,
    input  logic              ex_w1_we_i,
    input  id_pkg::reg_addr_t ex_w1_addr_i,
    input  id_pkg::word_t     ex_w1_data_i,
    input  logic              ex_w2_we_i,
    input  id_pkg::reg_addr_t ex_w2_addr_i,
    input  id_pkg::word_t     ex_w2_data_i,
    input  logic              mem_w1_we_i,
    input  id_pkg::reg_addr_t mem_w1_addr_i,
    input  id_pkg::word_t     mem_w1_data_i,
    input  logic              mem_w2_we_i,
    input  id_pkg::reg_addr_t mem_w2_addr_i,
    input  id_pkg::word_t     mem_w2_data_i,
    input  logic              wb_w1_we_i,
    input  id_pkg::reg_addr_t wb_w1_addr_i,
    input  id_pkg::word_t     wb_w1_data_i,
    input  logic              wb_w2_we_i,
    input  id_pkg::reg_addr_t wb_w2_addr_i,
    input  id_pkg::word_t     wb_w2_data_i,
    output id_pkg::word_t     opdata1_o,
    output id_pkg::word_t     opdata2_o
);

    // index 0 is the youngest result
    logic              fwd_we   [6];
    id_pkg::reg_addr_t fwd_addr [6];
    id_pkg::word_t     fwd_data [6];

    assign fwd_we   = '{ex_w2_we_i, ex_w1_we_i, mem_w2_we_i,
                        mem_w1_we_i, wb_w2_we_i, wb_w1_we_i};
    assign fwd_addr = '{ex_w2_addr_i, ex_w1_addr_i, mem_w2_addr_i,
                        mem_w1_addr_i, wb_w2_addr_i, wb_w1_addr_i};
    assign fwd_data = '{ex_w2_data_i, ex_w1_data_i, mem_w2_data_i,
                        mem_w1_data_i, wb_w2_data_i, wb_w1_data_i};

    function automatic id_pkg::word_t pick_operand(
        input logic              rd,
        input id_pkg::reg_addr_t src,
        input id_pkg::word_t     rf_data
    );
        id_pkg::word_t res;
        res = rf_data;
        // walk from oldest to youngest so the youngest match is kept
        for (int i = 5; i >= 0; i--) begin
            if (fwd_we[i] && (fwd_addr[i] == src) && (src != '0)) begin
                res = fwd_data[i];
            end
        end
        if (!rd) begin
            res = imm_i;
        end
        return res;
    endfunction

    always_comb begin
        opdata1_o = pick_operand(rs_read_i, rs_i, rf_rs_i);
        opdata2_o = pick_operand(rt_read_i, rt_i, rf_rt_i);
    end

endmodule

// File: id_stage.f
hdl/id_pkg.sv
hdl/id_slot_reg.sv
hdl/operand_fwd.sv
hdl/load_use_detect.sv
hdl/id_stage_ctrl.sv
hdl/id_stage.sv
bench/clk_gen.sv
bench/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator and run; pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f id_stage.f --top-module id_stage_tb -o id_stage_sim \
    && ./obj_dir/id_stage_sim | tee /dev/stderr \
    | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
